/* exec_stage.f */
+incdir+tb
logic/exec_pkg.sv
logic/alu_lane.sv
logic/mult_unit.sv
logic/hold_slot.sv
logic/completion_arbiter.sv
logic/exec_stage.sv
tb/tb_exec_stage.sv

/* Makefile */
# execute stage, Verilator build, run and lint

TOP := tb_exec_stage

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): exec_stage.f logic/*.sv tb/*.sv tb/*.svh
	verilator --binary --timing --top-module $(TOP) -f exec_stage.f -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@grep -qx "All checks passed" sim.log

lint:
	verilator --lint-only -Wall --top-module exec_stage logic/exec_pkg.sv \
		logic/alu_lane.sv logic/mult_unit.sv logic/hold_slot.sv \
		logic/completion_arbiter.sv logic/exec_stage.sv
	verilator --lint-only --timing --top-module $(TOP) -f exec_stage.f

clean:
	rm -rf obj_dir sim.log

/* tb/exec_checks.svh */
/*
 * execute stage reference model and typed compares
 * expected results built from the RISC-V operation rules
 */

`ifndef exec_checks_svh
`define exec_checks_svh

////////////////////
// reference model
////////////////////

// funct3 rule: bit 2 picks a less-than test, bit 1 unsigned, bit 0 inverts
function automatic logic branch_holds(input exec_pkg::alu_issue_t iss);
    logic less;
    logic base;
    if (iss.br_func[1]) begin
        less = iss.rs1 < iss.rs2;
    end else begin
        less = $signed(iss.rs1) < $signed(iss.rs2);
    end
    base = iss.br_func[2] ? less : (iss.rs1 == iss.rs2);
    return base ^ iss.br_func[0];
endfunction

function automatic exec_pkg::exec_result_t alu_model(input exec_pkg::alu_issue_t iss);
    logic [exec_pkg::xlen-1:0]   a;
    logic [exec_pkg::xlen-1:0]   b;
    logic [exec_pkg::xlen-1:0]   r;
    logic [2*exec_pkg::xlen-1:0] ext;
    logic                        take;
    int unsigned                 sh;
    exec_pkg::exec_result_t      res;
    case (iss.opa_sel)
        exec_pkg::opa_rs1: a = iss.rs1;
        exec_pkg::opa_npc: a = iss.npc;
        exec_pkg::opa_pc:  a = iss.pc;
        default:           a = '0;
    endcase
    b  = (iss.opb_sel == exec_pkg::opb_imm) ? iss.imm : iss.rs2;
    sh = int'(b[4:0]);
    r  = '0;
    case (iss.alu_func)
        exec_pkg::alu_add:  r = a + b;
        // two's complement negate then add
        exec_pkg::alu_sub:  r = a + ~b + 1'b1;
        exec_pkg::alu_and:  r = a & b;
        exec_pkg::alu_or:   r = a | b;
        exec_pkg::alu_xor:  r = a ^ b;
        exec_pkg::alu_slt:  r[0] = $signed(a) < $signed(b);
        exec_pkg::alu_sltu: r[0] = a < b;
        exec_pkg::alu_sll:  r = a << sh;
        exec_pkg::alu_srl:  r = a >> sh;
        exec_pkg::alu_sra: begin
            // sign copies shifted in from the upper half
            ext = {{exec_pkg::xlen{a[exec_pkg::xlen-1]}}, a} >> sh;
            r   = ext[exec_pkg::xlen-1:0];
        end
        default:            r = '0;
    endcase
    take            = iss.uncond_branch || (iss.cond_branch && branch_holds(iss));
    res.rob_tag     = iss.rob_tag;
    res.take_branch = take;
    // not-taken conditional falls through to npc
    res.value       = (iss.cond_branch && !take) ? iss.npc : r;
    return res;
endfunction

// 64-bit products are exact for every 32x32 variant
function automatic exec_pkg::exec_result_t mul_model(input exec_pkg::mul_issue_t iss);
    longint                 sa;
    longint                 sb;
    longint unsigned        ua;
    longint unsigned        ub;
    logic [63:0]            p;
    exec_pkg::exec_result_t res;
    ua = {32'b0, iss.rs1};
    ub = {32'b0, iss.rs2};
    sa = $signed(iss.rs1);
    case (iss.mul_func)
        exec_pkg::mul_mulh: begin
            sb = $signed(iss.rs2);
            p  = sa * sb;
        end
        exec_pkg::mul_mulhsu: begin
            sb = ub;
            p  = sa * sb;
        end
        default: p = ua * ub;
    endcase
    res.rob_tag     = iss.rob_tag;
    res.take_branch = 1'b0;
    res.value       = (iss.mul_func == exec_pkg::mul_mul) ? p[31:0] : p[63:32];
    return res;
endfunction

////////////////////
// compares
////////////////////

task automatic report_mismatch(input string sig, input logic [31:0] got,
                               input logic [31:0] exp);
    stop_with_failure($sformatf("Mismatch %s got %h expected %h", sig, got, exp));
endtask

// expected entry is looked up by the bus tag, so the payload is what differs
task automatic check_cdb(input exec_pkg::cdb_pkt_t got, input exec_pkg::exec_result_t exp);
    if (got.res.value !== exp.value) begin
        report_mismatch("cdb.res.value", got.res.value, exp.value);
    end else if (got.res.take_branch !== exp.take_branch) begin
        report_mismatch("cdb.res.take_branch", 32'(got.res.take_branch),
                        32'(exp.take_branch));
    end
endtask

task automatic check_addr(input exec_pkg::addr_pkt_t got, input exec_pkg::exec_result_t exp);
    if (got.addr !== exp.value) begin
        report_mismatch("addr_out.addr", got.addr, exp.value);
    end
endtask

task automatic check_busy(input exec_pkg::fu_busy_t got, input string name,
                          input exec_pkg::fu_busy_t exp);
    if (got !== exp) begin
        report_mismatch($sformatf("fu_busy (%s)", name), 32'(got), 32'(exp));
    end
endtask

`endif

/* tb/tb_exec_stage.sv */
/*
 * execute stage testbench
 * random issue on three lanes, random bus stalls, scoreboard by tag
 */

`timescale 1ns/100ps

module tb_exec_stage;

    localparam int clk_period = 8;
    localparam int n_ops      = 2000;
    localparam int timeout_ns = n_ops * 20 * clk_period;

    logic                          clk;
    logic                          rst;
    exec_pkg::alu_issue_t          alu0_issue;
    exec_pkg::alu_issue_t          alu1_issue;
    exec_pkg::mul_issue_t          mul_issue;
    logic                          cdb_busy;
    exec_pkg::cdb_pkt_t            cdb;
    exec_pkg::addr_pkt_t           addr_out;
    exec_pkg::fu_busy_t            fu_busy;

    // scoreboard, one entry per rob tag
    bit                            pending [32];
    bit                            sb_mem [32];
    exec_pkg::exec_result_t        sb_res [32];
    // issuing lane per tag, 0 alu0, 1 alu1, 2 mult
    bit [1:0]                      sb_lane [32];
    int                            outstanding;
    int                            issued;
    logic [exec_pkg::tag_bits-1:0] next_tag;
    logic                          busy_prev;

    exec_stage #(
        .mult_step_bits (8)
    ) u_exec_stage (
        .clk        (clk),
        .rst        (rst),
        .alu0_issue (alu0_issue),
        .alu1_issue (alu1_issue),
        .mul_issue  (mul_issue),
        .cdb_busy   (cdb_busy),
        .cdb        (cdb),
        .addr_out   (addr_out),
        .fu_busy    (fu_busy)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "stopped at the first failing check");
    endtask

    `include "exec_checks.svh"

    ////////////////////
    // stimulus
    ////////////////////

    // edge values now and then, sign bit and all ones matter for mulh
    function automatic logic [exec_pkg::xlen-1:0] data_word();
        case ($urandom_range(7))
            0:       return 32'h8000_0000;
            1:       return 32'hffff_ffff;
            2:       return 32'($urandom_range(31));
            default: return $urandom;
        endcase
    endfunction

    function automatic exec_pkg::alu_issue_t alu_stimulus(
        input logic [exec_pkg::tag_bits-1:0] tag
    );
        exec_pkg::alu_issue_t iss;
        logic [11:0]          imm12;
        int unsigned          kind;
        iss           = '0;
        imm12         = 12'($urandom);
        kind          = $urandom_range(7);
        iss.valid     = 1'b1;
        iss.rob_tag   = tag;
        iss.alu_func  = exec_pkg::alu_func_e'(4'($urandom_range(9)));
        iss.opa_sel   = exec_pkg::opa_sel_e'(2'($urandom_range(3)));
        iss.opb_sel   = exec_pkg::opb_sel_e'(1'($urandom_range(1)));
        iss.rs1       = data_word();
        // equal operands now and then so beq/bge get exercised
        iss.rs2       = ($urandom_range(3) == 0) ? iss.rs1 : data_word();
        iss.imm       = {{20{imm12[11]}}, imm12};
        iss.pc        = $urandom & 32'hffff_fffc;
        iss.npc       = iss.pc + 32'd4;
        case ($urandom_range(5))
            0:       iss.br_func = exec_pkg::br_beq;
            1:       iss.br_func = exec_pkg::br_bne;
            2:       iss.br_func = exec_pkg::br_blt;
            3:       iss.br_func = exec_pkg::br_bge;
            4:       iss.br_func = exec_pkg::br_bltu;
            default: iss.br_func = exec_pkg::br_bgeu;
        endcase
        // mix of conditional, jump, memory and plain ops
        case (kind)
            0, 1:    iss.cond_branch = 1'b1;
            2:       iss.uncond_branch = 1'b1;
            3, 4:    iss.is_mem = 1'b1;
            default: iss.is_mem = 1'b0;
        endcase
        return iss;
    endfunction

    function automatic exec_pkg::mul_issue_t mul_stimulus(
        input logic [exec_pkg::tag_bits-1:0] tag
    );
        exec_pkg::mul_issue_t iss;
        iss.valid    = 1'b1;
        iss.rob_tag  = tag;
        iss.mul_func = exec_pkg::mul_func_e'(2'($urandom_range(3)));
        iss.rs1      = data_word();
        iss.rs2      = data_word();
        return iss;
    endfunction

    task automatic record_expected(input exec_pkg::exec_result_t res, input bit is_mem,
                                   input bit [1:0] lane);
        if (pending[next_tag]) begin
            stop_with_failure($sformatf("tag %0d reused while still outstanding", next_tag));
        end else begin
            pending[next_tag] = 1'b1;
            sb_mem[next_tag]  = is_mem;
            sb_res[next_tag]  = res;
            sb_lane[next_tag] = lane;
            next_tag          = next_tag + 1'b1;
            issued            = issued + 1;
            outstanding       = outstanding + 1;
        end
    endtask

    // one strobe per idle lane at most, cdb_busy high about 30 percent
    task automatic drive_inputs(input bit allow_issue);
        alu0_issue = '0;
        alu1_issue = '0;
        mul_issue  = '0;
        if (allow_issue && !fu_busy.alu0 && issued < n_ops && $urandom_range(1) == 1) begin
            alu0_issue = alu_stimulus(next_tag);
            record_expected(alu_model(alu0_issue), alu0_issue.is_mem, 2'd0);
        end
        if (allow_issue && !fu_busy.alu1 && issued < n_ops && $urandom_range(1) == 1) begin
            alu1_issue = alu_stimulus(next_tag);
            record_expected(alu_model(alu1_issue), alu1_issue.is_mem, 2'd1);
        end
        if (allow_issue && !fu_busy.mult && issued < n_ops && $urandom_range(1) == 1) begin
            mul_issue = mul_stimulus(next_tag);
            record_expected(mul_model(mul_issue), 1'b0, 2'd2);
        end
        cdb_busy  = ($urandom_range(99) < 30);
        busy_prev = cdb_busy;
    endtask

    ////////////////////
    // output monitor
    ////////////////////

    // a lane stays busy until its result has left the stage
    function automatic exec_pkg::fu_busy_t busy_model();
        exec_pkg::fu_busy_t exp;
        int                 t;
        exp = '0;
        for (t = 0; t < 32; t++) begin
            if (pending[t]) begin
                case (sb_lane[t])
                    2'd0:    exp.alu0 = 1'b1;
                    2'd1:    exp.alu1 = 1'b1;
                    default: exp.mult = 1'b1;
                endcase
            end
        end
        return exp;
    endfunction

    task automatic watch_outputs();
        // registered bus saw the previous cycle's busy level
        if (busy_prev && cdb.valid) begin
            stop_with_failure("cdb valid in the cycle after cdb_busy was high");
        end else if (cdb.valid && !pending[cdb.res.rob_tag]) begin
            stop_with_failure($sformatf("cdb carried tag %0d with nothing outstanding",
                                        cdb.res.rob_tag));
        end else if (cdb.valid && sb_mem[cdb.res.rob_tag]) begin
            stop_with_failure($sformatf("memory op with tag %0d appeared on cdb",
                                        cdb.res.rob_tag));
        end else if (cdb.valid) begin
            check_cdb(cdb, sb_res[cdb.res.rob_tag]);
            pending[cdb.res.rob_tag] = 1'b0;
            outstanding              = outstanding - 1;
        end
        if (addr_out.valid && !pending[addr_out.rob_tag]) begin
            stop_with_failure($sformatf("addr_out carried tag %0d with nothing outstanding",
                                        addr_out.rob_tag));
        end else if (addr_out.valid && !sb_mem[addr_out.rob_tag]) begin
            stop_with_failure($sformatf("non-memory op with tag %0d appeared on addr_out",
                                        addr_out.rob_tag));
        end else if (addr_out.valid) begin
            check_addr(addr_out, sb_res[addr_out.rob_tag]);
            pending[addr_out.rob_tag] = 1'b0;
            outstanding               = outstanding - 1;
        end
        // results retired above no longer hold their lane
        check_busy(fu_busy, "lane state", busy_model());
    endtask

    task automatic clock_step(input bit allow_issue);
        @(negedge clk);
        watch_outputs();
        drive_inputs(allow_issue);
    endtask

    ////////////////////
    // run control
    ////////////////////

    initial begin
        #(timeout_ns);
        stop_with_failure($sformatf("run timed out after %0d ns with %0d results outstanding",
                                    timeout_ns, outstanding));
    end

    initial begin
        void'($urandom(32'h773f96c8));
        clk         = 1'b0;
        rst         = 1'b1;
        alu0_issue  = '0;
        alu1_issue  = '0;
        mul_issue   = '0;
        cdb_busy    = 1'b0;
        busy_prev   = 1'b0;
        next_tag    = '0;
        issued      = 0;
        outstanding = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // idle after reset, nothing issued yet
        @(negedge clk);
        if (cdb.valid !== 1'b0) begin
            report_mismatch("cdb.valid", 32'(cdb.valid), 32'd0);
        end
        if (addr_out.valid !== 1'b0) begin
            report_mismatch("addr_out.valid", 32'(addr_out.valid), 32'd0);
        end
        check_busy(fu_busy, "after reset", '0);
        drive_inputs(1'b1);
        while (issued < n_ops) begin
            clock_step(1'b1);
        end
        // drain, stalls still random
        while (outstanding != 0) begin
            clock_step(1'b0);
        end
        repeat (20) clock_step(1'b0);
        check_busy(fu_busy, "after drain", '0);
        $display("All checks passed");
        $finish;
    end

endmodule

/* logic/exec_stage.sv */
/*
 * execute stage top, two ALU lanes and one multiplier
 * per-lane hold slots feed the completion arbiter
 */

`timescale 1ns/100ps

module exec_stage #(
    parameter int mult_step_bits = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    input  exec_pkg::alu_issue_t alu0_issue,
    input  exec_pkg::alu_issue_t alu1_issue,
    input  exec_pkg::mul_issue_t mul_issue,
    input  logic                 cdb_busy,
    output exec_pkg::cdb_pkt_t   cdb,
    output exec_pkg::addr_pkt_t  addr_out,
    output exec_pkg::fu_busy_t   fu_busy
);

    // lane to slot
    logic                   alu0_fresh_valid;
    logic                   alu1_fresh_valid;
    logic                   mult_done;
    exec_pkg::alu_result_t  alu0_fresh;
    exec_pkg::alu_result_t  alu1_fresh;
    exec_pkg::exec_result_t mult_fresh;
    logic                   mult_busy;

    // slot to arbiter and back
    logic                   alu0_cand_valid;
    logic                   alu1_cand_valid;
    logic                   mult_cand_valid;
    exec_pkg::alu_result_t  alu0_cand;
    exec_pkg::alu_result_t  alu1_cand;
    exec_pkg::exec_result_t mult_cand;
    logic                   alu0_grant;
    logic                   alu1_grant;
    logic                   mult_grant;
    logic                   alu0_held;
    logic                   alu1_held;
    logic                   mult_held;

    ////////////////////
    // lanes
    ////////////////////

    alu_lane u_alu0_lane (
        .issue        (alu0_issue),
        .result_valid (alu0_fresh_valid),
        .result       (alu0_fresh)
    );

    alu_lane u_alu1_lane (
        .issue        (alu1_issue),
        .result_valid (alu1_fresh_valid),
        .result       (alu1_fresh)
    );

    mult_unit #(
        .mult_step_bits (mult_step_bits)
    ) u_mult_unit (
        .clk         (clk),
        .rst         (rst),
        .issue       (mul_issue),
        .result_held (mult_held),
        .busy        (mult_busy),
        .done        (mult_done),
        .result      (mult_fresh)
    );

    ////////////////////
    // hold slots
    ////////////////////

    hold_slot #(
        .payload_t (exec_pkg::alu_result_t)
    ) u_alu0_slot (
        .clk         (clk),
        .rst         (rst),
        .fresh_valid (alu0_fresh_valid),
        .fresh       (alu0_fresh),
        .grant       (alu0_grant),
        .cand_valid  (alu0_cand_valid),
        .cand        (alu0_cand),
        .held        (alu0_held)
    );

    hold_slot #(
        .payload_t (exec_pkg::alu_result_t)
    ) u_alu1_slot (
        .clk         (clk),
        .rst         (rst),
        .fresh_valid (alu1_fresh_valid),
        .fresh       (alu1_fresh),
        .grant       (alu1_grant),
        .cand_valid  (alu1_cand_valid),
        .cand        (alu1_cand),
        .held        (alu1_held)
    );

    hold_slot #(
        .payload_t (exec_pkg::exec_result_t)
    ) u_mult_slot (
        .clk         (clk),
        .rst         (rst),
        .fresh_valid (mult_done),
        .fresh       (mult_fresh),
        .grant       (mult_grant),
        .cand_valid  (mult_cand_valid),
        .cand        (mult_cand),
        .held        (mult_held)
    );

    ////////////////////
    // arbitration
    ////////////////////

    completion_arbiter u_completion_arbiter (
        .clk        (clk),
        .rst        (rst),
        .cdb_busy   (cdb_busy),
        .mult_valid (mult_cand_valid),
        .mult_cand  (mult_cand),
        .alu0_valid (alu0_cand_valid),
        .alu0_cand  (alu0_cand),
        .alu1_valid (alu1_cand_valid),
        .alu1_cand  (alu1_cand),
        .mult_grant (mult_grant),
        .alu0_grant (alu0_grant),
        .alu1_grant (alu1_grant),
        .cdb        (cdb),
        .addr_out   (addr_out)
    );

    // busy from registered state only
    assign fu_busy.alu0 = alu0_held;
    assign fu_busy.alu1 = alu1_held;
    assign fu_busy.mult = mult_busy;

endmodule

/* logic/completion_arbiter.sv */
/*
 * completion arbiter
 * fixed-priority picks for the result bus and the address port
 */

`timescale 1ns/100ps

module completion_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cdb_busy,
    input  logic                   mult_valid,
    input  exec_pkg::exec_result_t mult_cand,
    input  logic                   alu0_valid,
    input  exec_pkg::alu_result_t  alu0_cand,
    input  logic                   alu1_valid,
    input  exec_pkg::alu_result_t  alu1_cand,
    output logic                   mult_grant,
    output logic                   alu0_grant,
    output logic                   alu1_grant,
    output exec_pkg::cdb_pkt_t     cdb,
    output exec_pkg::addr_pkt_t    addr_out
);

    logic                          alu0_bus_req;
    logic                          alu1_bus_req;
    logic                          alu0_mem_req;
    logic                          alu1_mem_req;
    logic                          bus_mult;
    logic                          bus_alu0;
    logic                          bus_alu1;
    logic                          addr_alu0;
    logic                          addr_alu1;
    logic                          cdb_valid_q;
    exec_pkg::exec_result_t        cdb_res_q;
    logic                          addr_valid_q;
    logic [exec_pkg::tag_bits-1:0] addr_tag_q;
    logic [exec_pkg::xlen-1:0]     addr_q;

    // alu candidates split by destination
    assign alu0_bus_req = alu0_valid & ~alu0_cand.is_mem;
    assign alu1_bus_req = alu1_valid & ~alu1_cand.is_mem;
    assign alu0_mem_req = alu0_valid & alu0_cand.is_mem;
    assign alu1_mem_req = alu1_valid & alu1_cand.is_mem;

    ////////////////////
    // priority picks
    ////////////////////

    // bus order mult, alu0, alu1, nothing while downstream busy
    assign bus_mult = ~cdb_busy & mult_valid;
    assign bus_alu0 = ~cdb_busy & ~mult_valid & alu0_bus_req;
    assign bus_alu1 = ~cdb_busy & ~mult_valid & ~alu0_bus_req & alu1_bus_req;

    // address port ignores bus busy
    assign addr_alu0 = alu0_mem_req;
    assign addr_alu1 = ~alu0_mem_req & alu1_mem_req;

    assign mult_grant = bus_mult;
    assign alu0_grant = bus_alu0 | addr_alu0;
    assign alu1_grant = bus_alu1 | addr_alu1;

    ////////////////////
    // output registers
    ////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cdb_valid_q  <= 1'b0;
            addr_valid_q <= 1'b0;
        end else begin
            cdb_valid_q  <= bus_mult | bus_alu0 | bus_alu1;
            addr_valid_q <= addr_alu0 | addr_alu1;
        end
    end

    always_ff @(posedge clk) begin
        cdb_res_q  <= bus_mult ? mult_cand : (bus_alu0 ? alu0_cand.res : alu1_cand.res);
        // address port carries only tag and address
        addr_tag_q <= addr_alu0 ? alu0_cand.res.rob_tag : alu1_cand.res.rob_tag;
        addr_q     <= addr_alu0 ? alu0_cand.res.value : alu1_cand.res.value;
    end

    assign cdb.valid        = cdb_valid_q;
    assign cdb.res          = cdb_res_q;
    assign addr_out.valid   = addr_valid_q;
    assign addr_out.rob_tag = addr_tag_q;
    assign addr_out.addr    = addr_q;

endmodule

/* logic/hold_slot.sv */
/*
 * single-entry result buffer between a lane and the arbiter
 */

`timescale 1ns/100ps

module hold_slot #(
    parameter type payload_t = exec_pkg::exec_result_t
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     fresh_valid,
    input  payload_t fresh,
    input  logic     grant,
    output logic     cand_valid,
    output payload_t cand,
    output logic     held
);

    logic     held_q;
    payload_t entry;

    // empty slot is transparent
    assign cand_valid = held_q | fresh_valid;
    assign cand       = held_q ? entry : fresh;
    assign held       = held_q;

    // keep whatever lost arbitration this cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            held_q <= 1'b0;
        end else begin
            held_q <= cand_valid & ~grant;
        end
    end

    always_ff @(posedge clk) begin
        if (cand_valid && !grant) begin
            entry <= cand;
        end
    end

endmodule

/* logic/mult_unit.sv */
/*
 * iterative shift-add multiplier
 * mult_step_bits of the multiplier consumed per cycle, one op in flight
 */

`timescale 1ns/100ps

module mult_unit #(
    parameter int mult_step_bits = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  exec_pkg::mul_issue_t   issue,
    input  logic                   result_held,
    output logic                   busy,
    output logic                   done,
    output exec_pkg::exec_result_t result
);

    localparam int dbl_bits   = 2 * exec_pkg::xlen;
    localparam int num_steps  = dbl_bits / mult_step_bits;
    localparam int count_bits = $clog2(num_steps + 1);

    logic                          running;
    logic                          done_q;
    logic                          last_step;
    logic [count_bits-1:0]         step_cnt;
    logic [exec_pkg::tag_bits-1:0] tag_q;
    exec_pkg::mul_func_e           func_q;
    logic                          a_signed;
    logic                          b_signed;
    logic [dbl_bits-1:0]           mcand;
    logic [dbl_bits-1:0]           mplier;
    logic [dbl_bits-1:0]           product;
    logic [dbl_bits-1:0]           partial;

    // mulh signed x signed, mulhsu signed x unsigned
    assign a_signed = (issue.mul_func == exec_pkg::mul_mulh) ||
                      (issue.mul_func == exec_pkg::mul_mulhsu);
    assign b_signed = (issue.mul_func == exec_pkg::mul_mulh);

    // one slice of the multiplier against the shifted multiplicand
    assign partial = mcand * {{(dbl_bits-mult_step_bits){1'b0}},
                              mplier[mult_step_bits-1:0]};

    assign last_step = running && (step_cnt == count_bits'(num_steps - 1));

    ////////////////////
    // control
    ////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running  <= 1'b0;
            step_cnt <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= last_step;
            if (issue.valid) begin
                running  <= 1'b1;
                step_cnt <= '0;
            end else if (last_step) begin
                running <= 1'b0;
            end else if (running) begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

    ////////////////////
    // datapath
    ////////////////////

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            tag_q   <= issue.rob_tag;
            func_q  <= issue.mul_func;
            // extend to full width so the low 64 bits come out exact
            mcand   <= {{exec_pkg::xlen{a_signed & issue.rs1[exec_pkg::xlen-1]}}, issue.rs1};
            mplier  <= {{exec_pkg::xlen{b_signed & issue.rs2[exec_pkg::xlen-1]}}, issue.rs2};
            product <= '0;
        end else if (running) begin
            product <= product + partial;
            mcand   <= mcand << mult_step_bits;
            mplier  <= mplier >> mult_step_bits;
        end
    end

    assign done = done_q;

    // product is final during the done cycle
    assign result.rob_tag     = tag_q;
    assign result.value       = (func_q == exec_pkg::mul_mul) ? product[exec_pkg::xlen-1:0]
                                                              : product[dbl_bits-1:exec_pkg::xlen];
    assign result.take_branch = 1'b0;

    // done cycle counts as busy, slot may still capture it
    assign busy = running | done_q | result_held;

endmodule

/* logic/alu_lane.sv */
/*
 * ALU lane, purely combinational
 * operand select, integer op, branch condition and result shaping
 */

`timescale 1ns/100ps

module alu_lane (
    input  exec_pkg::alu_issue_t  issue,
    output logic                  result_valid,
    output exec_pkg::alu_result_t result
);

    logic [exec_pkg::xlen-1:0] opa;
    logic [exec_pkg::xlen-1:0] opb;
    logic [exec_pkg::xlen-1:0] alu_out;
    logic                      cond_true;
    logic                      take;

    ////////////////////
    // operand select
    ////////////////////

    always_comb begin
        case (issue.opa_sel)
            exec_pkg::opa_rs1:  opa = issue.rs1;
            exec_pkg::opa_npc:  opa = issue.npc;
            exec_pkg::opa_pc:   opa = issue.pc;
            exec_pkg::opa_zero: opa = '0;
            default:            opa = '0;
        endcase
    end

    // immediate arrives pre-extended
    assign opb = (issue.opb_sel == exec_pkg::opb_imm) ? issue.imm : issue.rs2;

    ////////////////////
    // alu
    ////////////////////

    always_comb begin
        case (issue.alu_func)
            exec_pkg::alu_add:  alu_out = opa + opb;
            exec_pkg::alu_sub:  alu_out = opa - opb;
            exec_pkg::alu_and:  alu_out = opa & opb;
            exec_pkg::alu_or:   alu_out = opa | opb;
            exec_pkg::alu_xor:  alu_out = opa ^ opb;
            // compares zero-extend a single bit
            exec_pkg::alu_slt:  alu_out = {{(exec_pkg::xlen-1){1'b0}},
                                           $signed(opa) < $signed(opb)};
            exec_pkg::alu_sltu: alu_out = {{(exec_pkg::xlen-1){1'b0}}, opa < opb};
            // shift amount from low 5 bits only
            exec_pkg::alu_sll:  alu_out = opa << opb[4:0];
            exec_pkg::alu_srl:  alu_out = opa >> opb[4:0];
            exec_pkg::alu_sra:  alu_out = $signed(opa) >>> opb[4:0];
            default:            alu_out = '0;
        endcase
    end

    ////////////////////
    // branch condition
    ////////////////////

    // always on rs1/rs2, not on the selected operands
    always_comb begin
        case (issue.br_func)
            exec_pkg::br_beq:  cond_true = issue.rs1 == issue.rs2;
            exec_pkg::br_bne:  cond_true = issue.rs1 != issue.rs2;
            exec_pkg::br_blt:  cond_true = $signed(issue.rs1) < $signed(issue.rs2);
            exec_pkg::br_bge:  cond_true = $signed(issue.rs1) >= $signed(issue.rs2);
            exec_pkg::br_bltu: cond_true = issue.rs1 < issue.rs2;
            exec_pkg::br_bgeu: cond_true = issue.rs1 >= issue.rs2;
            default:           cond_true = 1'b0;
        endcase
    end

    // jumps always taken, conditionals only when condition holds
    assign take = issue.uncond_branch | (issue.cond_branch & cond_true);

    ////////////////////
    // result shaping
    ////////////////////

    assign result_valid = issue.valid;

    assign result.res.rob_tag     = issue.rob_tag;
    assign result.res.take_branch = take;
    // fall-through target when a conditional is not taken
    assign result.res.value       = (issue.cond_branch && !take) ? issue.npc : alu_out;
    // for loads/stores the alu result is the effective address
    assign result.is_mem          = issue.is_mem;

endmodule

/* logic/exec_pkg.sv */
/*
 * execute stage shared definitions
 * widths, operation encodings and the packets passed between lanes
 */

package exec_pkg;

    ////////////////////
    // widths
    ////////////////////

    parameter int xlen     = 32;
    parameter int tag_bits = 5;

    ////////////////////
    // operation encodings
    ////////////////////

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_func_e;

    // low word for mul, high word for the rest
    typedef enum logic [1:0] {
        mul_mul,
        mul_mulh,
        mul_mulhsu,
        mul_mulhu
    } mul_func_e;

    typedef enum logic [1:0] {
        opa_rs1,
        opa_npc,
        opa_pc,
        opa_zero
    } opa_sel_e;

    typedef enum logic {
        opb_rs2,
        opb_imm
    } opb_sel_e;

    // same values as funct3 of the branch opcodes
    typedef enum logic [2:0] {
        br_beq  = 3'b000,
        br_bne  = 3'b001,
        br_blt  = 3'b100,
        br_bge  = 3'b101,
        br_bltu = 3'b110,
        br_bgeu = 3'b111
    } br_func_e;

    ////////////////////
    // packets
    ////////////////////

    typedef struct packed {
        logic                valid;
        logic [tag_bits-1:0] rob_tag;
        alu_func_e           alu_func;
        opa_sel_e            opa_sel;
        opb_sel_e            opb_sel;
        logic [xlen-1:0]     rs1;
        logic [xlen-1:0]     rs2;
        // already sign-extended by decode
        logic [xlen-1:0]     imm;
        logic [xlen-1:0]     pc;
        logic [xlen-1:0]     npc;
        logic                cond_branch;
        logic                uncond_branch;
        br_func_e            br_func;
        logic                is_mem;
    } alu_issue_t;

    typedef struct packed {
        logic                valid;
        logic [tag_bits-1:0] rob_tag;
        mul_func_e           mul_func;
        logic [xlen-1:0]     rs1;
        logic [xlen-1:0]     rs2;
    } mul_issue_t;

    typedef struct packed {
        logic [tag_bits-1:0] rob_tag;
        logic [xlen-1:0]     value;
        logic                take_branch;
    } exec_result_t;

    typedef struct packed {
        exec_result_t res;
        logic         is_mem;
    } alu_result_t;

    typedef struct packed {
        logic         valid;
        exec_result_t res;
    } cdb_pkt_t;

    typedef struct packed {
        logic                valid;
        logic [tag_bits-1:0] rob_tag;
        logic [xlen-1:0]     addr;
    } addr_pkt_t;

    typedef struct packed {
        logic alu0;
        logic alu1;
        logic mult;
    } fu_busy_t;

endpackage
